//--- include/cic_cfg.svh
`ifndef CIC_CFG_SVH
`define CIC_CFG_SVH

// filter structure
`define CIC_STAGES 2 // integrator count, same as comb count
`define CIC_DECIM 4 // decimation ratio R, fixed at build time

// input side widths
`define CIC_SAMPLE_W 13 // signed input sample
`define CIC_GAIN_W 5 // signed per-sample gain

// product width, as wide as the multiply slice output it replaces
`define CIC_PROD_W 23

// accumulator growth is stages * log2(R) bits on top of the product
// 23 + 2 * 2 = 27, so the comb output is exact under wrap
`define CIC_ACC_W 27

// multiply section depth
// two input regs, one multiplier reg, one product reg
`define CIC_MULT_LAT 4

`endif

//--- source/cic_pkg.sv
`include "cic_cfg.svh"

package cic_pkg;

    // raw input sample from the converter
    typedef logic signed [`CIC_SAMPLE_W-1:0] sample_t;

    // gain word, sampled alongside each sample
    typedef logic signed [`CIC_GAIN_W-1:0] gain_t;

    // gain times sample, full width with spare headroom
    typedef logic signed [`CIC_PROD_W-1:0] prod_t;

    // integrator and comb word, wraps modulo 2**CIC_ACC_W
    typedef logic signed [`CIC_ACC_W-1:0] acc_t;

endpackage

//--- source/dsp48_integrator_section_0.sv
`timescale 1ns/1ps

`include "cic_cfg.svh"

module dsp48_integrator_section_0 (
    input  logic             clk,
    input  logic             rst,
    input  cic_pkg::gain_t   a, // gain
    input  cic_pkg::sample_t b, // sample
    input  logic             in_valid,
    output cic_pkg::prod_t   p,
    output logic             p_valid
);

    import cic_pkg::*;

    localparam int LAT = `CIC_MULT_LAT; // must stay 4 to match the data regs below

    gain_t   a_reg1; // first a stage
    gain_t   a_reg2; // second a stage
    sample_t b_reg1; // first b stage
    sample_t b_reg2; // second b stage
    prod_t   m_reg; // multiplier output reg
    prod_t   p_reg; // product output reg

    logic [LAT-1:0] vld_sr; // valid delay line, bit 0 is newest

    // data path, free running like the slice pipeline regs
    always_ff @(posedge clk) begin
        a_reg1 <= a; // capture stage
        b_reg1 <= b;
        a_reg2 <= a_reg1; // second input stage
        b_reg2 <= b_reg1;
        m_reg  <= a_reg2 * b_reg2; // operands sign extend to product width
        p_reg  <= m_reg;
    end

    // strobe follows the data through the same four regs
    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[LAT-2:0], in_valid}; // shift toward msb
        end
    end

    assign p       = p_reg;
    assign p_valid = vld_sr[LAT-1]; // high 4 cycles after in_valid

endmodule

//--- source/cic_integrator.sv
`timescale 1ns/1ps

`include "cic_cfg.svh"

module cic_integrator (
    input  logic           clk,
    input  logic           rst,
    input  cic_pkg::prod_t p,
    input  logic           p_valid,
    output cic_pkg::acc_t  integ,
    output logic           integ_valid
);

    import cic_pkg::*;

    localparam int STAGES = `CIC_STAGES;

    acc_t acc [STAGES]; // running sums, one per stage
    logic vld [STAGES]; // per stage strobe, one cycle apart

    acc_t p_ext; // product widened to accumulator width

    assign p_ext = acc_t'(p); // signed cast, sign extends

    // each stage adds once per item, so gaps just hold the sums
    // overflow wraps on purpose, the combs undo it
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                acc[i] <= '0;
                vld[i] <= 1'b0;
            end
        end else begin
            vld[0] <= p_valid;
            if (p_valid) begin
                acc[0] <= acc[0] + p_ext; // first stage eats the product
            end
            for (int i = 1; i < STAGES; i++) begin
                vld[i] <= vld[i-1]; // stage i sees stage i-1 one cycle late
                if (vld[i-1]) begin
                    acc[i] <= acc[i] + acc[i-1]; // registered value of previous stage
                end
            end
        end
    end

    assign integ       = acc[STAGES-1];
    assign integ_valid = vld[STAGES-1]; // STAGES cycles after p_valid

endmodule

//--- source/cic_decimator.sv
`timescale 1ns/1ps

`include "cic_cfg.svh"

module cic_decimator (
    input  logic          clk,
    input  logic          rst,
    input  cic_pkg::acc_t integ,
    input  logic          integ_valid,
    output cic_pkg::acc_t decim,
    output logic          decim_valid
);

    import cic_pkg::*;

    localparam int DECIM = `CIC_DECIM;
    localparam int CNT_W = $clog2(DECIM);

    logic [CNT_W-1:0] cnt; // item count modulo R
    logic             last; // current item is the one kept
    acc_t             decim_reg; // held output word

    assign last = (cnt == CNT_W'(DECIM - 1));

    // count items, not cycles, so idle gaps leave the phase alone
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt         <= '0;
            decim_valid <= 1'b0;
        end else begin
            decim_valid <= integ_valid && last; // one pulse per R items
            if (integ_valid) begin
                cnt <= last ? '0 : cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (integ_valid && last) begin
            decim_reg <= integ; // only every Rth word is kept
        end
    end

    assign decim = decim_reg;

endmodule

//--- source/cic_comb.sv
`timescale 1ns/1ps

`include "cic_cfg.svh"

module cic_comb (
    input  logic          clk,
    input  logic          rst,
    input  cic_pkg::acc_t decim,
    input  logic          decim_valid,
    output cic_pkg::acc_t out_sample,
    output logic          out_valid
);

    import cic_pkg::*;

    localparam int STAGES = `CIC_STAGES;

    acc_t dly [STAGES]; // previous item seen by each stage, M = 1
    acc_t y   [STAGES]; // stage outputs
    logic vld [STAGES]; // stage strobes

    // control and delay state, zero after reset so the first
    // differences start from a known history
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < STAGES; i++) begin
                dly[i] <= '0;
                vld[i] <= 1'b0;
            end
        end else begin
            vld[0] <= decim_valid;
            if (decim_valid) begin
                dly[0] <= decim; // remember current item
            end
            for (int i = 1; i < STAGES; i++) begin
                vld[i] <= vld[i-1];
                if (vld[i-1]) begin
                    dly[i] <= y[i-1];
                end
            end
        end
    end

    // first differences, wrap matches the integrator wrap
    always_ff @(posedge clk) begin
        if (decim_valid) begin
            y[0] <= decim - dly[0];
        end
        for (int i = 1; i < STAGES; i++) begin
            if (vld[i-1]) begin
                y[i] <= y[i-1] - dly[i]; // one cycle per stage
            end
        end
    end

    assign out_sample = y[STAGES-1];
    assign out_valid  = vld[STAGES-1];

endmodule

//--- source/cic_decim_top.sv
`timescale 1ns/1ps

module cic_decim_top (
    input  logic             clk,
    input  logic             rst,
    input  cic_pkg::gain_t   gain, // may change every sample
    input  cic_pkg::sample_t sample,
    input  logic             in_valid,
    output cic_pkg::acc_t    out_sample,
    output logic             out_valid // 9 cycles after every 4th in_valid
);

    import cic_pkg::*;

    prod_t p; // gain * sample
    logic  p_valid;
    acc_t  integ; // last integrator output
    logic  integ_valid;
    acc_t  decim; // every 4th integrator word
    logic  decim_valid;

    // 4 cycles
    dsp48_integrator_section_0 u_mult (
        .clk      (clk),
        .rst      (rst),
        .a        (gain),
        .b        (sample),
        .in_valid (in_valid),
        .p        (p),
        .p_valid  (p_valid)
    );

    // 2 cycles
    cic_integrator u_integ (
        .clk         (clk),
        .rst         (rst),
        .p           (p),
        .p_valid     (p_valid),
        .integ       (integ),
        .integ_valid (integ_valid)
    );

    // 1 cycle
    cic_decimator u_decim (
        .clk         (clk),
        .rst         (rst),
        .integ       (integ),
        .integ_valid (integ_valid),
        .decim       (decim),
        .decim_valid (decim_valid)
    );

    // 2 cycles, decimated rate
    cic_comb u_comb (
        .clk         (clk),
        .rst         (rst),
        .decim       (decim),
        .decim_valid (decim_valid),
        .out_sample  (out_sample),
        .out_valid   (out_valid)
    );

endmodule

//--- sim/cic_decim_tb.sv
`timescale 1ns/1ps

`include "cic_cfg.svh"

module cic_decim_tb;

    import cic_pkg::*;

    localparam int n_rows       = 8;
    localparam int out_lat      = `CIC_MULT_LAT + 2 * `CIC_STAGES + 1; // 4 + 2 + 1 + 2 = 9
    localparam int mode_const   = 0;
    localparam int mode_impulse = 1;
    localparam int mode_random  = 2;
    localparam int mode_gapped  = 3; // replays the random row with idle cycles

    logic    clk;
    logic    rst;
    gain_t   gain;
    sample_t sample;
    logic    in_valid;
    acc_t    out_sample;
    logic    out_valid;

    // test table with one entry per row
    string row_name  [n_rows];
    int    row_gain  [n_rows];
    int    row_base  [n_rows];
    int    row_count [n_rows];
    int    row_mode  [n_rows];
    int    row_exp   [n_rows]; // expected last output
    bit    row_chk   [n_rows]; // last output is checked
    int    n_added;

    // bit-true model state for 2 integrators and 2 combs
    logic signed [`CIC_ACC_W-1:0] m_i1;
    logic signed [`CIC_ACC_W-1:0] m_i2;
    logic signed [`CIC_ACC_W-1:0] m_d1;
    logic signed [`CIC_ACC_W-1:0] m_d2;
    int                           m_cnt; // accepted samples modulo R

    acc_t exp_val [$]; // expected outputs in order
    int   exp_cyc [$]; // cycle each one should show up
    acc_t got_seq [$]; // outputs seen in the current test
    acc_t ref_seq [$]; // outputs of the ungapped random run

    logic [31:0] data_lfsr;
    logic [31:0] gap_lfsr;
    logic [31:0] replay_state; // data lfsr state at start of the random row

    int    cyc;
    int    limit;
    int    errors;
    int    checks;
    int    tests_ok;
    int    tests_bad;
    string cur_name;

    cic_decim_top u_cic_decim_top (
        .clk        (clk),
        .rst        (rst),
        .gain       (gain),
        .sample     (sample),
        .in_valid   (in_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    // cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (limit > 0 && cyc >= limit) begin
            $display("timeout: run stopped at cycle %0d, limit was %0d", cyc, limit);
            $display("sim failed");
            $finish;
        end
    end

    // output monitor samples mid cycle where out_sample is stable
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_val.size() == 0) begin
                $display("%s: out_valid went high at %0d ns with no output expected",
                         cur_name, $time);
                errors++;
            end else begin
                checks++;
                if (out_sample !== exp_val[0]) begin
                    $display("FAILED %0d ns: %s out_sample %0d, expected %0d",
                             $time, cur_name, out_sample, exp_val[0]);
                    errors++;
                end
                if (cyc != exp_cyc[0]) begin
                    $display("FAILED %0d ns: %s output at cycle %0d, expected cycle %0d",
                             $time, cur_name, cyc, exp_cyc[0]);
                    errors++;
                end
                void'(exp_val.pop_front());
                void'(exp_cyc.pop_front());
                got_seq.push_back(out_sample);
            end
        end
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit taken with the msb first
    task automatic draw_bits(inout logic [31:0] state, input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            state = lfsr_next(state);
            val   = {val[30:0], state[0]};
        end
    endtask

    task automatic add_row(input string name, input int g, input int x, input int n,
                           input int mode, input int exp_last, input bit chk);
        row_name[n_added]  = name;
        row_gain[n_added]  = g;
        row_base[n_added]  = x;
        row_count[n_added] = n; // multiple of R so nothing carries over
        row_mode[n_added]  = mode;
        row_exp[n_added]   = exp_last;
        row_chk[n_added]   = chk;
        n_added++;
    endtask

    // reference model that multiplies, integrates with wrap, keeps every 4th and combs
    task automatic model_accept(input gain_t g, input sample_t x, input int drive_cyc);
        logic signed [31:0]           prod;
        logic signed [`CIC_ACC_W-1:0] pe;
        logic signed [`CIC_ACC_W-1:0] c1;
        logic signed [`CIC_ACC_W-1:0] c2;
        prod  = g * x; // both signed so the full product fits in 32 bits
        pe    = prod[`CIC_ACC_W-1:0];
        m_i1  = m_i1 + pe;
        m_i2  = m_i2 + m_i1; // sums wrap at 27 bits
        m_cnt = m_cnt + 1;
        if (m_cnt == `CIC_DECIM) begin
            m_cnt = 0;
            c1    = m_i2 - m_d1;
            m_d1  = m_i2;
            c2    = c1 - m_d2;
            m_d2  = c1;
            exp_val.push_back(c2);
            exp_cyc.push_back(drive_cyc + out_lat);
        end
    endtask

    task automatic apply_reset;
        @(posedge clk);
        #5;
        rst      = 1'b1;
        in_valid = 1'b0;
        repeat (3) @(posedge clk);
        #5;
        rst   = 1'b0;
        m_i1  = '0;
        m_i2  = '0;
        m_d1  = '0;
        m_d2  = '0;
        m_cnt = 0;
        exp_val.delete();
        exp_cyc.delete();
    endtask

    task automatic idle_cycle;
        @(posedge clk);
        #5;
        in_valid = 1'b0;
    endtask

    task automatic drive_sample(input gain_t g, input sample_t x);
        @(posedge clk);
        #5;
        gain     = g;
        sample   = x;
        in_valid = 1'b1;
        model_accept(g, x, cyc); // sampled by the DUT on the next edge
    endtask

    task automatic run_row(input int r);
        int          err0;
        int          waited;
        logic [31:0] v;
        gain_t       g;
        sample_t     x;
        err0     = errors;
        cur_name = row_name[r];
        apply_reset();
        got_seq.delete();
        repeat (3) idle_cycle(); // quiet after reset so the monitor flags any output
        if (row_mode[r] == mode_random) begin
            replay_state = data_lfsr;
        end
        if (row_mode[r] == mode_gapped) begin
            data_lfsr = replay_state; // same samples as the random row
        end
        for (int i = 0; i < row_count[r]; i++) begin
            g = row_gain[r][`CIC_GAIN_W-1:0];
            x = row_base[r][`CIC_SAMPLE_W-1:0];
            if (row_mode[r] == mode_impulse && i != 1) begin
                x = '0; // impulse sits at index 1
            end
            if (row_mode[r] == mode_random || row_mode[r] == mode_gapped) begin
                draw_bits(data_lfsr, `CIC_SAMPLE_W, v);
                x = v[`CIC_SAMPLE_W-1:0];
                draw_bits(data_lfsr, `CIC_GAIN_W, v);
                g = v[`CIC_GAIN_W-1:0]; // new gain every sample
            end
            if (row_mode[r] == mode_gapped) begin
                draw_bits(gap_lfsr, 1, v);
                if (v[0]) begin
                    idle_cycle();
                end
            end
            drive_sample(g, x);
        end
        idle_cycle();
        waited = 0;
        while (exp_val.size() != 0 && waited < out_lat + 4) begin
            @(posedge clk);
            waited++;
        end
        if (exp_val.size() != 0) begin
            $display("%s: %0d expected outputs never appeared", cur_name, exp_val.size());
            errors += exp_val.size();
            exp_val.delete();
            exp_cyc.delete();
        end
        if (row_chk[r]) begin
            if (got_seq.size() == 0) begin
                $display("%s: no output seen, cannot check the settled value", cur_name);
                errors++;
            end else if (got_seq[got_seq.size()-1] !== acc_t'(row_exp[r])) begin
                $display("FAILED %0d ns: %s last output %0d, expected %0d", $time,
                         cur_name, got_seq[got_seq.size()-1], row_exp[r]);
                errors++;
            end
        end
        if (row_mode[r] == mode_random) begin
            ref_seq = got_seq;
        end
        if (row_mode[r] == mode_gapped) begin
            if (got_seq.size() != ref_seq.size()) begin
                $display("%s: %0d outputs with gaps but %0d without", cur_name,
                         got_seq.size(), ref_seq.size());
                errors++;
            end else begin
                for (int i = 0; i < got_seq.size(); i++) begin
                    if (got_seq[i] !== ref_seq[i]) begin
                        $display("FAILED %0d ns: %s output %0d is %0d, ungapped run gave %0d",
                                 $time, cur_name, i, got_seq[i], ref_seq[i]);
                        errors++;
                    end
                end
            end
        end
        if (errors == err0) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("test %-16s outputs %0d errors %0d %s", cur_name, got_seq.size(),
                 errors - err0, (errors == err0) ? "ok" : "BAD");
    endtask

    initial begin
        int total;
        rst       = 1'b1;
        gain      = '0;
        sample    = '0;
        in_valid  = 1'b0;
        cyc       = 0;
        limit     = 0;
        errors    = 0;
        checks    = 0;
        tests_ok  = 0;
        tests_bad = 0;
        n_added   = 0;
        cur_name  = "reset";
        data_lfsr = 32'h2d0d;
        gap_lfsr  = 32'h2d0d;
        // dc rows settle to x * g * 16
        add_row("dc_small", 3, 100, 16, mode_const, 4800, 1'b1);
        add_row("dc_neg_sample", 7, -1500, 16, mode_const, -168000, 1'b1);
        add_row("dc_neg_gain", -9, 2000, 20, mode_const, -288000, 1'b1);
        add_row("dc_neg_wrap", -16, -4096, 64, mode_const, 1048576, 1'b1); // integrators wrap
        add_row("dc_max_wrap", 15, 4095, 64, mode_const, 982800, 1'b1);
        add_row("impulse", 5, -3000, 16, mode_impulse, 0, 1'b1); // tail must be zero
        add_row("random", 0, 0, 128, mode_random, 0, 1'b0);
        add_row("gapped", 0, 0, 128, mode_gapped, 0, 1'b0); // must follow random
        total = 0;
        for (int r = 0; r < n_rows; r++) begin
            total += row_count[r];
        end
        limit = 2 * total + 9 * n_rows + 100;
        for (int r = 0; r < n_rows; r++) begin
            run_row(r);
        end
        $display("tests %0d, ok %0d, bad %0d, outputs checked %0d, errors %0d",
                 n_rows, tests_ok, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+include
source/cic_pkg.sv
source/dsp48_integrator_section_0.sv
source/cic_integrator.sv
source/cic_decimator.sv
source/cic_comb.sv
source/cic_decim_top.sv
sim/cic_decim_tb.sv

//--- Bender.yml
package:
  name: cic_decim

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cic_pkg.sv
      - source/dsp48_integrator_section_0.sv
      - source/cic_integrator.sv
      - source/cic_decimator.sv
      - source/cic_comb.sv
      - source/cic_decim_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/cic_decim_tb.sv
